/* logic/conv_engine_macros.svh */
`ifndef CONV_ENGINE_MACROS_SVH
`define CONV_ENGINE_MACROS_SVH

// Words per atom and number of MAC lanes
`define BURST_LEN 16

// Data word width
`define WORD_W 16

// DMA word address width
`define ADDR_W 30

// Loop counter and layer size width
`define CNT_W 16

`endif

/* logic/conv_engine_pkg.sv */
`include "conv_engine_macros.svh"

package conv_engine_pkg;

	// Layer configuration, held stable from start to done
	typedef struct packed {
		logic [`CNT_W-1:0]  kernel;       // Kernel side
		logic [`CNT_W-1:0]  stride;
		logic [`CNT_W-1:0]  groups;       // Input channel groups of BURST_LEN
		logic [`CNT_W-1:0]  o_channel;    // Output channels
		logic [`CNT_W-1:0]  i_side;       // Input feature map side
		logic [`CNT_W-1:0]  o_side;       // Output feature map side
		logic [`ADDR_W-1:0] data_start;
		logic [`ADDR_W-1:0] weight_start;
		logic [`ADDR_W-1:0] result_start;
	} conv_cfg_t;

	// DMA read request, en is a one cycle pulse
	typedef struct packed {
		logic               en;
		logic [`ADDR_W-1:0] addr;
	} dma_rd_req_t;

	// DMA read response, one we strobe per word
	typedef struct packed {
		logic               we;
		logic [`WORD_W-1:0] data;
	} dma_rd_rsp_t;

	// DMA write request
	typedef struct packed {
		logic               en;     // Level, held until the DMA answers
		logic [`ADDR_W-1:0] addr;
		logic               valid;  // Pulse that carries data
		logic [`WORD_W-1:0] data;
	} dma_wr_req_t;

	// One atom, word l belongs to lane l
	typedef logic [`BURST_LEN-1:0][`WORD_W-1:0] atom_t;

	// Layer sequencer states
	typedef enum logic [2:0] {
		ST_IDLE,
		ST_FETCH,    // Waiting for data and weight atoms
		ST_STEP,     // MAC step in flight
		ST_HANDOFF,  // Pixel done, reducer still busy
		ST_DONE      // Last pixel handed off
	} seq_state_e;

endpackage

/* logic/burst_deserializer.sv */
`timescale 1ns/10ps
`include "conv_engine_macros.svh"

module burst_deserializer (
	input  logic                         i_clk,
	input  logic                         i_rst,
	input  conv_engine_pkg::dma_rd_rsp_t i_rsp,
	output conv_engine_pkg::atom_t       o_atom,
	output logic                         o_atom_valid
);

	localparam int CNT_W = $clog2(`BURST_LEN);

	logic [CNT_W-1:0] word_cnt;  // Strobes seen in this burst
	logic             last_word;

	assign last_word = word_cnt == CNT_W'(`BURST_LEN - 1);

	// Words enter at the top, first word ends up in lane 0
	always_ff @(posedge i_clk) begin
		if (i_rsp.we)
			o_atom <= {i_rsp.data, o_atom[`BURST_LEN-1:1]};
	end

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			word_cnt     <= '0;
			o_atom_valid <= 1'b0;
		end else begin
			o_atom_valid <= i_rsp.we && last_word;  // One cycle after the last strobe
			if (i_rsp.we)
				word_cnt <= last_word ? '0 : word_cnt + 1'b1;
		end
	end

	// Next request only goes out after the atom is taken
	a_no_early_strobe: assert property (@(posedge i_clk) disable iff (i_rst)
		!(i_rsp.we && o_atom_valid));

endmodule

/* logic/mac_array.sv */
`timescale 1ns/10ps
`include "conv_engine_macros.svh"

module mac_array (
	input  logic                   i_clk,
	input  logic                   i_rst,
	input  logic                   i_step,
	input  logic                   i_clear,
	input  conv_engine_pkg::atom_t i_data,
	input  conv_engine_pkg::atom_t i_wgt,
	output conv_engine_pkg::atom_t o_acc
);

	conv_engine_pkg::atom_t prod;  // Lane products, low 16 bits

	always_comb begin
		for (int l = 0; l < `BURST_LEN; l++) begin
			prod[l] = i_data[l] * i_wgt[l];
		end
	end

	// One accumulator per lane, updated only on a step
	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			o_acc <= '0;
		end else if (i_step) begin
			for (int l = 0; l < `BURST_LEN; l++) begin
				if (i_clear)
					o_acc[l] <= prod[l];  // First tap of a pixel
				else
					o_acc[l] <= o_acc[l] + prod[l];
			end
		end
	end

endmodule

/* logic/channel_reducer.sv */
`timescale 1ns/10ps
`include "conv_engine_macros.svh"

module channel_reducer (
	input  logic                         i_clk,
	input  logic                         i_rst,
	input  logic                         i_reduce,
	input  logic [`ADDR_W-1:0]           i_addr,
	input  conv_engine_pkg::atom_t       i_acc,
	output logic                         o_busy,
	output conv_engine_pkg::dma_wr_req_t o_wr,
	input  logic                         i_wr_re
);

	localparam int LANE_W = $clog2(`BURST_LEN);

	conv_engine_pkg::atom_t acc_q;     // Latched lanes shifted down one per add
	logic [`ADDR_W-1:0]     addr_q;
	logic [`WORD_W-1:0]     sum;       // Pixel result
	logic [LANE_W-1:0]      lane_cnt;
	logic                   adding;
	logic                   wr_en, wr_valid;

	assign o_wr.en    = wr_en;
	assign o_wr.addr  = addr_q;
	assign o_wr.valid = wr_valid;
	assign o_wr.data  = sum;

	// Payload path
	always_ff @(posedge i_clk) begin
		if (i_reduce) begin
			acc_q  <= i_acc;
			addr_q <= i_addr;
			sum    <= '0;
		end else if (adding) begin
			sum   <= sum + acc_q[0];
			acc_q <= {`WORD_W'(0), acc_q[`BURST_LEN-1:1]};
		end
	end

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			o_busy   <= 1'b0;
			adding   <= 1'b0;
			lane_cnt <= '0;
			wr_en    <= 1'b0;
			wr_valid <= 1'b0;
		end else begin
			wr_valid <= 1'b0;
			if (i_reduce) begin
				o_busy   <= 1'b1;
				adding   <= 1'b1;
				lane_cnt <= '0;
			end else if (adding) begin
				lane_cnt <= lane_cnt + 1'b1;
				if (lane_cnt == LANE_W'(`BURST_LEN - 1)) begin
					adding <= 1'b0;
					wr_en  <= 1'b1;  // Sum final on the next cycle
				end
			end
			// DMA ready so en drops and the word goes out
			if (wr_en && i_wr_re) begin
				wr_en    <= 1'b0;
				wr_valid <= 1'b1;
			end
			if (wr_valid)
				o_busy <= 1'b0;
		end
	end

	// Valid answers i_wr_re and carries the address that en held
	a_valid_after_re: assert property (@(posedge i_clk) disable iff (i_rst)
		o_wr.valid |-> $past(i_wr_re) && $stable(o_wr.addr));

endmodule

/* logic/layer_sequencer.sv */
`timescale 1ns/10ps
`include "conv_engine_macros.svh"

module layer_sequencer (
	input  logic                         i_clk,
	input  logic                         i_rst,
	input  logic                         i_start,
	input  conv_engine_pkg::conv_cfg_t   i_cfg,
	input  logic                         i_data_atom_valid,
	input  logic                         i_wgt_atom_valid,
	input  logic                         i_reducer_busy,
	output conv_engine_pkg::dma_rd_req_t o_data_rd,
	output conv_engine_pkg::dma_rd_req_t o_wgt_rd,
	output logic                         o_mac_step,
	output logic                         o_mac_clear,
	output logic                         o_reduce,
	output logic [`ADDR_W-1:0]           o_result_addr,
	output logic                         o_done
);

	conv_engine_pkg::seq_state_e state;

	logic [`CNT_W-1:0]  oc_cnt, r_cnt, c_cnt;   // Output pixel position
	logic [`CNT_W-1:0]  g_cnt, kr_cnt, kc_cnt;  // Tap inside the pixel
	logic               data_rd_en, wgt_rd_en;
	logic               data_got, wgt_got;      // Atom already arrived
	logic               last_kc, last_kr, last_g, last_c, last_r, last_oc;
	logic               last_tap, last_pix, first_tap;
	logic               step_done, advance, hand;
	logic [`ADDR_W-1:0] in_row, in_col, data_addr, wgt_addr, res_addr;

	assign last_kc   = kc_cnt == i_cfg.kernel - 1'b1;
	assign last_kr   = kr_cnt == i_cfg.kernel - 1'b1;
	assign last_g    = g_cnt == i_cfg.groups - 1'b1;
	assign last_c    = c_cnt == i_cfg.o_side - 1'b1;
	assign last_r    = r_cnt == i_cfg.o_side - 1'b1;
	assign last_oc   = oc_cnt == i_cfg.o_channel - 1'b1;
	assign last_tap  = last_g && last_kr && last_kc;
	assign last_pix  = last_tap && last_c && last_r && last_oc;
	assign first_tap = g_cnt == '0 && kr_cnt == '0 && kc_cnt == '0;

	// Counters still point at the tap just stepped
	assign step_done = state == conv_engine_pkg::ST_STEP || state == conv_engine_pkg::ST_HANDOFF;
	assign advance   = step_done && (!last_tap || !i_reducer_busy);
	assign hand      = advance && last_tap;  // Pixel goes to the reducer

	// Input pixel under the kernel tap
	assign in_row = r_cnt * i_cfg.stride + kr_cnt;
	assign in_col = c_cnt * i_cfg.stride + kc_cnt;

	assign data_addr = i_cfg.data_start
		+ ((g_cnt * i_cfg.i_side + in_row) * i_cfg.i_side + in_col) * `ADDR_W'(`BURST_LEN);
	assign wgt_addr = i_cfg.weight_start
		+ (((oc_cnt * i_cfg.groups + g_cnt) * i_cfg.kernel + kr_cnt) * i_cfg.kernel + kc_cnt)
		* `ADDR_W'(`BURST_LEN);
	assign res_addr = i_cfg.result_start + (oc_cnt * i_cfg.o_side + r_cnt) * i_cfg.o_side + c_cnt;

	// Address follows the counters, en is registered
	assign o_data_rd.en   = data_rd_en;
	assign o_data_rd.addr = data_addr;
	assign o_wgt_rd.en    = wgt_rd_en;
	assign o_wgt_rd.addr  = wgt_addr;

	// Loop counters, kc innermost and oc outermost
	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			{oc_cnt, r_cnt, c_cnt, g_cnt, kr_cnt, kc_cnt} <= '0;
		end else if (advance) begin
			kc_cnt <= last_kc ? '0 : kc_cnt + 1'b1;
			if (last_kc) begin
				kr_cnt <= last_kr ? '0 : kr_cnt + 1'b1;
				if (last_kr) begin
					g_cnt <= last_g ? '0 : g_cnt + 1'b1;
					if (last_g) begin
						c_cnt <= last_c ? '0 : c_cnt + 1'b1;
						if (last_c) begin
							r_cnt <= last_r ? '0 : r_cnt + 1'b1;
							if (last_r) begin
								oc_cnt <= last_oc ? '0 : oc_cnt + 1'b1;  // Wraps to zero at layer end
							end
						end
					end
				end
			end
		end
	end

	// Layer state machine
	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			state       <= conv_engine_pkg::ST_IDLE;
			data_rd_en  <= 1'b0;
			wgt_rd_en   <= 1'b0;
			data_got    <= 1'b0;
			wgt_got     <= 1'b0;
			o_mac_step  <= 1'b0;
			o_mac_clear <= 1'b0;
			o_reduce    <= 1'b0;
			o_done      <= 1'b0;
		end else begin
			data_rd_en  <= 1'b0;  // Pulses
			wgt_rd_en   <= 1'b0;
			o_mac_step  <= 1'b0;
			o_mac_clear <= 1'b0;
			o_reduce    <= 1'b0;
			o_done      <= 1'b0;
			case (state)
				conv_engine_pkg::ST_IDLE: begin
					if (i_start) begin
						data_rd_en <= 1'b1;
						wgt_rd_en  <= 1'b1;
						data_got   <= 1'b0;
						wgt_got    <= 1'b0;
						state      <= conv_engine_pkg::ST_FETCH;
					end
				end
				conv_engine_pkg::ST_FETCH: begin
					if (i_data_atom_valid)
						data_got <= 1'b1;
					if (i_wgt_atom_valid)
						wgt_got <= 1'b1;
					// Both atoms held, step on the next cycle
					if ((data_got || i_data_atom_valid) && (wgt_got || i_wgt_atom_valid)) begin
						data_got    <= 1'b0;
						wgt_got     <= 1'b0;
						o_mac_step  <= 1'b1;
						o_mac_clear <= first_tap;  // New pixel restarts the lanes
						state       <= conv_engine_pkg::ST_STEP;
					end
				end
				conv_engine_pkg::ST_STEP, conv_engine_pkg::ST_HANDOFF: begin
					if (hand)
						o_reduce <= 1'b1;
					if (!advance) begin
						state <= conv_engine_pkg::ST_HANDOFF;  // Reducer still on the previous pixel
					end else if (hand && last_pix) begin
						state <= conv_engine_pkg::ST_DONE;
					end else begin
						data_rd_en <= 1'b1;  // Fetch the next tap
						wgt_rd_en  <= 1'b1;
						state      <= conv_engine_pkg::ST_FETCH;
					end
				end
				conv_engine_pkg::ST_DONE: begin
					// Busy rises only after the reduce pulse
					if (!i_reducer_busy && !o_reduce) begin
						o_done <= 1'b1;
						state  <= conv_engine_pkg::ST_IDLE;
					end
				end
				default: state <= conv_engine_pkg::ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clk) begin
		if (hand)
			o_result_addr <= res_addr;  // Pixel address goes with the reduce pulse
	end

	// Handoff only to an idle reducer
	a_reduce_idle: assert property (@(posedge i_clk) disable iff (i_rst)
		!(o_reduce && i_reducer_busy));

endmodule

/* logic/conv_engine.sv */
`timescale 1ns/10ps
`include "conv_engine_macros.svh"

module conv_engine (
	input  logic                         i_clk,
	input  logic                         i_rst,
	input  logic                         i_start,
	input  conv_engine_pkg::conv_cfg_t   i_cfg,
	output conv_engine_pkg::dma_rd_req_t o_data_rd,
	input  conv_engine_pkg::dma_rd_rsp_t i_data_rsp,
	output conv_engine_pkg::dma_rd_req_t o_wgt_rd,
	input  conv_engine_pkg::dma_rd_rsp_t i_wgt_rsp,
	output conv_engine_pkg::dma_wr_req_t o_wr,
	input  logic                         i_wr_re,
	output logic                         o_done
);

	conv_engine_pkg::atom_t data_atom;    // Deserialized input channels
	conv_engine_pkg::atom_t wgt_atom;     // Deserialized weights
	conv_engine_pkg::atom_t lane_acc;     // Per lane running sums
	logic                   data_atom_valid;
	logic                   wgt_atom_valid;
	logic                   mac_step;
	logic                   mac_clear;
	logic                   reduce;
	logic [`ADDR_W-1:0]     result_addr;
	logic                   reducer_busy;

	// Loop control and address generation
	layer_sequencer u_seq (
		.i_clk             (i_clk),
		.i_rst             (i_rst),
		.i_start           (i_start),
		.i_cfg             (i_cfg),
		.i_data_atom_valid (data_atom_valid),
		.i_wgt_atom_valid  (wgt_atom_valid),
		.i_reducer_busy    (reducer_busy),
		.o_data_rd         (o_data_rd),
		.o_wgt_rd          (o_wgt_rd),
		.o_mac_step        (mac_step),
		.o_mac_clear       (mac_clear),
		.o_reduce          (reduce),
		.o_result_addr     (result_addr),
		.o_done            (o_done)
	);

	burst_deserializer u_data_deser (
		.i_clk        (i_clk),
		.i_rst        (i_rst),
		.i_rsp        (i_data_rsp),
		.o_atom       (data_atom),
		.o_atom_valid (data_atom_valid)
	);

	burst_deserializer u_wgt_deser (
		.i_clk        (i_clk),
		.i_rst        (i_rst),
		.i_rsp        (i_wgt_rsp),
		.o_atom       (wgt_atom),
		.o_atom_valid (wgt_atom_valid)
	);

	mac_array u_mac (
		.i_clk   (i_clk),
		.i_rst   (i_rst),
		.i_step  (mac_step),
		.i_clear (mac_clear),
		.i_data  (data_atom),
		.i_wgt   (wgt_atom),
		.o_acc   (lane_acc)
	);

	// Lane sum and write back, overlaps the next pixel
	channel_reducer u_red (
		.i_clk    (i_clk),
		.i_rst    (i_rst),
		.i_reduce (reduce),
		.i_addr   (result_addr),
		.i_acc    (lane_acc),
		.o_busy   (reducer_busy),
		.o_wr     (o_wr),
		.i_wr_re  (i_wr_re)
	);

endmodule

/* verification/tb_dma_model.sv */
`timescale 1ns/10ps
`include "conv_engine_macros.svh"

module tb_dma_model (
	input  logic                         i_clk,
	input  logic                         i_rst,
	input  logic [31:0]                  i_seed,     // LCG seed for strobe gaps
	input  logic [3:0]                   i_max_gap,  // 0 gives back to back strobes
	input  conv_engine_pkg::dma_rd_req_t i_req,
	output conv_engine_pkg::dma_rd_rsp_t o_rsp
);

	localparam int DEPTH = 2048;

	logic [`WORD_W-1:0]           mem [DEPTH];  // Filled by the testbench through hierarchy
	logic [`ADDR_W-1:0]           rd_addr;      // Next word of the burst
	logic [31:0]                  gap_rng;
	conv_engine_pkg::dma_rd_rsp_t rsp_q = '0;   // Idle response from time zero
	int                           words_left;
	int                           gap_left;     // Idle cycles before the next strobe
	int                           proto_errs = 0;

	assign o_rsp = rsp_q;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic int pick_gap(input logic [31:0] s, input logic [3:0] max_gap);
		return int'(s[23:16]) % (int'(max_gap) + 1);  // Upper bits since the low ones cycle fast
	endfunction

	// Strobes change on the falling edge and the engine samples on the rising one
	always @(negedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			rsp_q      <= '0;
			rd_addr    <= '0;
			gap_rng    <= i_seed;
			words_left <= 0;
			gap_left   <= 0;
		end else begin
			rsp_q.we <= 1'b0;
			if (i_req.en) begin
				if (words_left != 0) begin
					$display("DMA model %m got a read request while a burst was still open");
					proto_errs <= proto_errs + 1;
				end
				rd_addr    <= i_req.addr;
				words_left <= `BURST_LEN;
				gap_left   <= pick_gap(gap_rng, i_max_gap);
				gap_rng    <= lcg_next(gap_rng);
			end else if (words_left != 0) begin
				if (gap_left != 0) begin
					gap_left <= gap_left - 1;
				end else if (rd_addr >= DEPTH) begin
					$display("DMA model %m read outside its memory at address %0d", rd_addr);
					proto_errs <= proto_errs + 1;
					words_left <= 0;  // Abandon the burst
				end else begin
					rsp_q.we   <= 1'b1;
					rsp_q.data <= mem[rd_addr];
					rd_addr    <= rd_addr + 1'b1;
					words_left <= words_left - 1;
					gap_left   <= pick_gap(gap_rng, i_max_gap);
					gap_rng    <= lcg_next(gap_rng);
				end
			end
		end
	end

endmodule

/* verification/tb_conv_engine.sv */
`timescale 1ns/10ps
`include "conv_engine_macros.svh"

module tb_conv_engine;

	localparam logic [31:0] SEED      = 32'h2179_42e6;
	localparam int          TIMEOUT   = 100000;  // Cycles per wait
	localparam int          RES_DEPTH = 1024;

	logic                         clk   = 1'b0;
	logic                         rst   = 1'b1;
	logic                         start = 1'b0;
	conv_engine_pkg::conv_cfg_t   cfg   = '0;
	conv_engine_pkg::dma_rd_req_t data_rd, wgt_rd;
	conv_engine_pkg::dma_rd_rsp_t data_rsp, wgt_rsp;
	conv_engine_pkg::dma_wr_req_t wr;
	logic                         wr_re = 1'b0;
	logic                         done;
	logic [3:0]                   rd_gap = '0;  // Strobe gap limit for both memories
	logic [3:0]                   wr_gap = '0;  // Delay limit before i_wr_re
	logic [31:0]                  rng = SEED;   // Memory fill
	logic [31:0]                  wr_rng;
	int                           wr_wait;
	logic [`WORD_W-1:0]           got [RES_DEPTH];
	bit                           written [RES_DEPTH];
	int                           wr_count, done_count;
	int                           value_errs = 0;
	int                           other_errs = 0;
	int                           k, s, grp, och, isd, osd;  // Current layer shape
	int                           d0, w0, r0;                // Start addresses

	always #4 clk = ~clk;

	conv_engine UUT (
		.i_clk      (clk),
		.i_rst      (rst),
		.i_start    (start),
		.i_cfg      (cfg),
		.o_data_rd  (data_rd),
		.i_data_rsp (data_rsp),
		.o_wgt_rd   (wgt_rd),
		.i_wgt_rsp  (wgt_rsp),
		.o_wr       (wr),
		.i_wr_re    (wr_re),
		.o_done     (done)
	);

	tb_dma_model u_data_mem (
		.i_clk     (clk),
		.i_rst     (rst),
		.i_seed    (SEED),
		.i_max_gap (rd_gap),
		.i_req     (data_rd),
		.o_rsp     (data_rsp)
	);

	tb_dma_model u_wgt_mem (
		.i_clk     (clk),
		.i_rst     (rst),
		.i_seed    (~SEED),  // Own gap pattern
		.i_max_gap (rd_gap),
		.i_req     (wgt_rd),
		.o_rsp     (wgt_rsp)
	);

	function automatic logic [31:0] lcg_next(input logic [31:0] v);
		return v * 32'd1664525 + 32'd1013904223;
	endfunction

	// Write side of the DMA answers en with a one cycle i_wr_re after a random delay
	always @(negedge clk or posedge rst) begin
		if (rst) begin
			wr_re   <= 1'b0;
			wr_rng  <= SEED ^ 32'h5a5a_0f0f;
			wr_wait <= 0;
		end else begin
			wr_re <= 1'b0;
			if (wr.en && !wr_re) begin
				if (wr_wait != 0) begin
					wr_wait <= wr_wait - 1;
				end else begin
					wr_re   <= 1'b1;
					wr_rng  <= lcg_next(wr_rng);
					wr_wait <= int'(wr_rng[23:16]) % (int'(wr_gap) + 1);  // Delay for the next write
				end
			end
		end
	end

	// Output capture sees the values from before the rising edge
	always @(posedge clk) begin
		if (!rst && wr.valid) begin
			if (wr.addr >= RES_DEPTH) begin
				$display("Write outside the result area at address %0d", wr.addr);
				other_errs++;
			end else if (written[wr.addr]) begin
				$display("Second write to result address %0d", wr.addr);
				other_errs++;
			end else begin
				written[wr.addr] = 1'b1;
				got[wr.addr]     = wr.data;
			end
			wr_count++;
		end
		if (!rst && done)
			done_count++;
	end

	task automatic apply_reset();
		rst = 1'b1;
		repeat (10) @(negedge clk);
		rst = 1'b0;
	endtask

	task automatic fill_memories();
		for (int a = 0; a < grp * isd * isd * `BURST_LEN; a++) begin
			rng = lcg_next(rng);
			u_data_mem.mem[d0 + a] = rng[31:16];
		end
		for (int a = 0; a < och * grp * k * k * `BURST_LEN; a++) begin
			rng = lcg_next(rng);
			u_wgt_mem.mem[w0 + a] = rng[31:16];
		end
	endtask

	// Reference result straight from the convolution sum with only the low 16 bits kept
	function automatic logic [`WORD_W-1:0] expected_pixel(input int oc, input int r, input int c);
		logic [`WORD_W-1:0] acc;
		int                 d_idx, w_idx;
		acc = '0;
		for (int g = 0; g < grp; g++)
			for (int kr = 0; kr < k; kr++)
				for (int kc = 0; kc < k; kc++)
					for (int l = 0; l < `BURST_LEN; l++) begin
						d_idx = d0 + ((g * isd + r * s + kr) * isd + c * s + kc) * `BURST_LEN + l;
						w_idx = w0 + (((oc * grp + g) * k + kr) * k + kc) * `BURST_LEN + l;
						acc   = acc + u_data_mem.mem[d_idx] * u_wgt_mem.mem[w_idx];
					end
		return acc;
	endfunction

	task automatic run_layer(input string name, input int kernel, input int stride,
		input int groups, input int o_ch, input int o_side, input bit refill);
		int                 cycles;
		int                 addr;
		logic [`WORD_W-1:0] exp_word;
		k   = kernel;
		s   = stride;
		grp = groups;
		och = o_ch;
		osd = o_side;
		isd = (o_side - 1) * stride + kernel;  // No padding
		if (refill)
			fill_memories();
		@(negedge clk);
		cfg.kernel       = `CNT_W'(k);
		cfg.stride       = `CNT_W'(s);
		cfg.groups       = `CNT_W'(grp);
		cfg.o_channel    = `CNT_W'(och);
		cfg.i_side       = `CNT_W'(isd);
		cfg.o_side       = `CNT_W'(osd);
		cfg.data_start   = `ADDR_W'(d0);
		cfg.weight_start = `ADDR_W'(w0);
		cfg.result_start = `ADDR_W'(r0);
		wr_count   = 0;
		done_count = 0;
		for (int a = 0; a < RES_DEPTH; a++)
			written[a] = 1'b0;
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		cycles = 0;
		while (done_count == 0 && cycles < TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		if (done_count == 0) begin
			$display("%s: timed out waiting for o_done", name);
			other_errs++;
			apply_reset();  // Recover for the next test
		end else begin
			repeat (4) @(negedge clk);  // Window for a stray second pulse
			assert (done_count == 1) else begin
				$display("ERR %s: o_done pulses expected 1 actual %0d", name, done_count);
				value_errs++;
			end
		end
		for (int oc = 0; oc < och; oc++)
			for (int r = 0; r < osd; r++)
				for (int c = 0; c < osd; c++) begin
					addr     = r0 + (oc * osd + r) * osd + c;
					exp_word = expected_pixel(oc, r, c);
					if (!written[addr]) begin
						$display("%s: no result was written to address %0d", name, addr);
						other_errs++;
					end else begin
						assert (got[addr] == exp_word) else begin
							$display("ERR %s: addr %0d expected %h actual %h",
								name, addr, exp_word, got[addr]);
							value_errs++;
						end
					end
				end
		assert (wr_count == och * osd * osd) else begin
			$display("ERR %s: write count expected %0d actual %0d", name, och * osd * osd, wr_count);
			value_errs++;
		end
	endtask

	task automatic pointwise_layer();
		d0     = 0;
		w0     = 0;
		r0     = 16;
		rd_gap = 0;
		wr_gap = 0;
		run_layer("pointwise", 1, 1, 1, 1, 2, 1'b1);
	endtask

	task automatic group_accumulation();
		d0 = 64;
		w0 = 100;
		r0 = 300;
		run_layer("groups", 3, 1, 2, 1, 3, 1'b1);
	endtask

	// Same memories as the groups test with slow strobes and a slow write side
	task automatic backpressure_layer();
		d0     = 64;
		w0     = 100;
		r0     = 700;
		rd_gap = 7;
		wr_gap = 15;
		run_layer("backpressure", 3, 1, 2, 1, 3, 1'b0);
		rd_gap = 0;
		wr_gap = 0;
	endtask

	task automatic strided_layer();
		d0 = 1024;
		w0 = 512;
		r0 = 500;
		run_layer("stride", 3, 2, 1, 2, 2, 1'b1);
	endtask

	task automatic reset_and_rerun();
		apply_reset();
		repeat (20) begin
			assert (!data_rd.en && !wgt_rd.en && !wr.en && !done) else begin
				$display("reset_rerun: a DMA enable or o_done went high before i_start");
				other_errs++;
			end
			@(negedge clk);
		end
		rd_gap = 3;
		wr_gap = 3;
		d0     = 0;
		w0     = 0;
		r0     = 16;
		run_layer("rerun_first", 1, 1, 1, 1, 2, 1'b1);
		d0 = 64;
		w0 = 100;
		r0 = 300;
		run_layer("rerun_second", 3, 1, 2, 1, 3, 1'b1);  // Straight after the first done
	endtask

	initial begin
		apply_reset();
		pointwise_layer();
		group_accumulation();
		backpressure_layer();
		strided_layer();
		reset_and_rerun();
		other_errs = other_errs + u_data_mem.proto_errs + u_wgt_mem.proto_errs;
		$display("Errors: %0d wrong values, %0d other failures", value_errs, other_errs);
		if (value_errs == 0 && other_errs == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

/* project.f */
+incdir+logic
logic/conv_engine_pkg.sv
logic/burst_deserializer.sv
logic/mac_array.sv
logic/channel_reducer.sv
logic/layer_sequencer.sv
logic/conv_engine.sv
verification/tb_dma_model.sv
verification/tb_conv_engine.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_conv_engine
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then \
		echo "Simulation reported a failure"; exit 1; \
	fi
	@if ! grep -q "TEST OK" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
